// ==== common/rename_pkg.sv ====
package rename_pkg;

	////////////////////
	// widths and types
	////////////////////

	localparam int ARF_SIZE = 32;              // architectural regs, fixed by the isa
	localparam int ARF_BITS = $clog2(ARF_SIZE);
	localparam int TAG_BITS = 6;               // room for a prf of up to 63 plus no-reg

	typedef logic [ARF_BITS-1:0] arch_reg_t;   // architectural register index
	typedef logic [TAG_BITS-1:0] prf_tag_t;    // physical register tag
	typedef logic [31:0]         inst_t;       // raw instruction word

	localparam arch_reg_t ZERO_REG = arch_reg_t'(31); // reads as zero, never renamed

	////////////////////
	// opcodes
	////////////////////

	// integer operate group
	localparam logic [5:0] OP_INTA = 6'h10;
	localparam logic [5:0] OP_INTL = 6'h11;
	localparam logic [5:0] OP_INTS = 6'h12;
	localparam logic [5:0] OP_INTM = 6'h13;

	// loads
	localparam logic [5:0] OP_LDL = 6'h28;
	localparam logic [5:0] OP_LDQ = 6'h29;

	// stores
	localparam logic [5:0] OP_STL = 6'h2C;
	localparam logic [5:0] OP_STQ = 6'h2D;

	// conditional branches, whole range
	localparam logic [5:0] OP_BR_LO = 6'h38;
	localparam logic [5:0] OP_BR_HI = 6'h3F;

endpackage

// ==== rat/rat.sv ====
`timescale 1ns/1ps

module rat #(
	parameter int PRF_SIZE = 48
) (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic                                           recover,
	input  rename_pkg::arch_reg_t                          opa_arch1,
	input  rename_pkg::arch_reg_t                          opb_arch1,
	input  rename_pkg::arch_reg_t                          dest_arch1,
	input  rename_pkg::arch_reg_t                          opa_arch2,
	input  rename_pkg::arch_reg_t                          opb_arch2,
	input  rename_pkg::arch_reg_t                          dest_arch2,
	input  logic                                           opa_used1,
	input  logic                                           opb_used1,
	input  logic                                           dest_used1,
	input  logic                                           opa_used2,
	input  logic                                           opb_used2,
	input  logic                                           dest_used2,
	input  rename_pkg::prf_tag_t                           free_tag1,
	input  rename_pkg::prf_tag_t                           free_tag2,
	input  logic                                           free_ok1,
	input  logic                                           free_ok2,
	input  rename_pkg::prf_tag_t [rename_pkg::ARF_SIZE-1:0] committed_map,
	output rename_pkg::prf_tag_t                           opa_tag1,
	output rename_pkg::prf_tag_t                           opb_tag1,
	output rename_pkg::prf_tag_t                           dest_tag1,
	output rename_pkg::prf_tag_t                           opa_tag2,
	output rename_pkg::prf_tag_t                           opb_tag2,
	output rename_pkg::prf_tag_t                           dest_tag2,
	output logic                                           halt1,
	output logic                                           halt2,
	output logic [1:0]                                     alloc_count,
	output logic [PRF_SIZE-1:0]                            recover_free
);
	import rename_pkg::*;

	localparam prf_tag_t NO_REG = prf_tag_t'(PRF_SIZE);

	prf_tag_t [ARF_SIZE-1:0] map;       // speculative map
	prf_tag_t [ARF_SIZE-1:0] map_next;
	prf_tag_t                tag2;      // tag left over for slot 2
	logic                    go1;       // slot accepted this cycle
	logic                    go2;
	logic                    take1;     // slot allocates a tag
	logic                    take2;

	////////////////////
	// halts and allocation
	////////////////////

	assign halt1 = ~recover & dest_used1 & ~free_ok1;
	assign halt2 = ~recover & (halt1 | (dest_used2 & (dest_used1 ? ~free_ok2 : ~free_ok1)));
	assign go1   = ~recover & ~halt1;                   // recover flushes both slots
	assign go2   = ~recover & ~halt2;
	assign take1 = go1 & dest_used1;
	assign take2 = go2 & dest_used2;
	assign tag2  = dest_used1 ? free_tag2 : free_tag1;  // slot 1 takes first

	assign alloc_count = {1'b0, take1} + {1'b0, take2};

	////////////////////
	// source lookup
	////////////////////

	assign opa_tag1  = (go1 & opa_used1) ? map[opa_arch1] : NO_REG;
	assign opb_tag1  = (go1 & opb_used1) ? map[opb_arch1] : NO_REG;
	assign dest_tag1 = take1 ? free_tag1 : NO_REG;

	// slot 2 reads slot 1's new tag when names match
	assign opa_tag2 = ~(go2 & opa_used2) ? NO_REG :
		(take1 && dest_arch1 == opa_arch2) ? free_tag1 : map[opa_arch2];
	assign opb_tag2 = ~(go2 & opb_used2) ? NO_REG :
		(take1 && dest_arch1 == opb_arch2) ? free_tag1 : map[opb_arch2];
	assign dest_tag2 = take2 ? tag2 : NO_REG;

	////////////////////
	// map update
	////////////////////

	always_comb begin
		map_next = map;
		if (recover) begin
			map_next = committed_map;             // back to the committed state
		end else begin
			if (take1) map_next[dest_arch1] = free_tag1;
			if (take2) map_next[dest_arch2] = tag2;  // slot 2 wins on same dest
		end
	end

	// every speculative mapping that differs from the rrat goes back to the list
	always_comb begin
		recover_free = '0;
		if (recover) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				if (map[i] != committed_map[i]) recover_free[map[i]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ARF_SIZE; i++) map[i] <= prf_tag_t'(i);  // identity map
		end else begin
			map <= map_next;
		end
	end

endmodule

// ==== rename_stage.f ====
+incdir+test
common/rename_pkg.sv
rtl/rename_decode.sv
rat/rat.sv
rtl/prf_free_list.sv
rtl/rrat.sv
rtl/rename_stage.sv
test/rename_stage_tb.sv

// ==== rtl/prf_free_list.sv ====
`timescale 1ns/1ps

module prf_free_list #(
	parameter int PRF_SIZE = 48
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 recover,
	input  logic [1:0]           alloc_count,
	input  logic [PRF_SIZE-1:0]  recover_free,
	input  rename_pkg::prf_tag_t retire_free_tag,
	input  logic                 retire_free_valid,
	output rename_pkg::prf_tag_t free_tag1,
	output rename_pkg::prf_tag_t free_tag2,
	output logic                 free_ok1,
	output logic                 free_ok2
);
	import rename_pkg::*;

	localparam prf_tag_t NO_REG = prf_tag_t'(PRF_SIZE);

	logic [PRF_SIZE-1:0] free_bits;       // one bit per tag, high when free
	logic [PRF_SIZE-1:0] free_next;

	////////////////////
	// two lowest free tags
	////////////////////

	always_comb begin
		free_tag1 = NO_REG;
		free_tag2 = NO_REG;
		free_ok1  = 1'b0;
		free_ok2  = 1'b0;
		for (int t = 0; t < PRF_SIZE; t++) begin
			if (free_bits[t]) begin
				if (!free_ok1) begin
					free_tag1 = prf_tag_t'(t);   // lowest
					free_ok1  = 1'b1;
				end else if (!free_ok2) begin
					free_tag2 = prf_tag_t'(t);   // second lowest
					free_ok2  = 1'b1;
				end
			end
		end
	end

	////////////////////
	// update
	////////////////////

	always_comb begin
		free_next = free_bits;
		if (!recover) begin                 // nothing is taken in a flush cycle
			if (alloc_count != 2'd0) free_next[free_tag1] = 1'b0;
			if (alloc_count == 2'd2) free_next[free_tag2] = 1'b0;
		end
		if (retire_free_valid) free_next[retire_free_tag] = 1'b1;
		free_next = free_next | recover_free;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int t = 0; t < PRF_SIZE; t++) begin
				free_bits[t] <= (t >= ARF_SIZE);  // low tags hold the identity map
			end
		end else begin
			free_bits <= free_next;
		end
	end

endmodule

// ==== rtl/rename_decode.sv ====
`timescale 1ns/1ps

module rename_decode (
	input  rename_pkg::inst_t     inst1,
	input  rename_pkg::inst_t     inst2,
	input  logic                  inst1_valid,
	input  logic                  inst2_valid,
	output rename_pkg::arch_reg_t opa_arch1,
	output rename_pkg::arch_reg_t opb_arch1,
	output rename_pkg::arch_reg_t dest_arch1,
	output rename_pkg::arch_reg_t opa_arch2,
	output rename_pkg::arch_reg_t opb_arch2,
	output rename_pkg::arch_reg_t dest_arch2,
	output logic                  opa_used1,
	output logic                  opb_used1,
	output logic                  dest_used1,
	output logic                  opa_used2,
	output logic                  opb_used2,
	output logic                  dest_used2
);
	import rename_pkg::*;

	// packs {opa, opa_used, opb, opb_used, dest, dest_used}
	function automatic logic [17:0] decode_slot(input inst_t inst, input logic valid);
		logic [5:0] opcode;
		arch_reg_t  ra;
		arch_reg_t  rb;
		arch_reg_t  dest;
		logic       use_a;
		logic       use_b;
		logic       use_d;
		opcode = inst[31:26];
		ra     = inst[25:21];
		rb     = inst[20:16];
		dest   = inst[4:0];                       // rc by default
		use_a  = 1'b0;
		use_b  = 1'b0;
		use_d  = 1'b0;
		if (opcode >= OP_INTA && opcode <= OP_INTM) begin
			use_a = 1'b1;
			use_b = ~inst[12];                    // literal form has no rb
			use_d = 1'b1;
		end else if (opcode == OP_LDL || opcode == OP_LDQ) begin
			use_b = 1'b1;                         // base address in rb
			use_d = 1'b1;
			dest  = ra;                           // loads write ra
		end else if (opcode == OP_STL || opcode == OP_STQ) begin
			use_a = 1'b1;                         // store data
			use_b = 1'b1;                         // base address
		end else if (opcode >= OP_BR_LO && opcode <= OP_BR_HI) begin
			use_a = 1'b1;                         // tested register
		end
		return {ra, use_a & valid & (ra != ZERO_REG),
			rb, use_b & valid & (rb != ZERO_REG),
			dest, use_d & valid & (dest != ZERO_REG)};
	endfunction

	assign {opa_arch1, opa_used1, opb_arch1, opb_used1, dest_arch1, dest_used1} =
		decode_slot(inst1, inst1_valid);
	assign {opa_arch2, opa_used2, opb_arch2, opb_used2, dest_arch2, dest_used2} =
		decode_slot(inst2, inst2_valid);

endmodule

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage #(
	parameter int PRF_SIZE = 48
) (
	input  logic                  clock,
	input  logic                  reset,
	input  rename_pkg::inst_t     inst1,
	input  logic                  inst1_valid,
	input  rename_pkg::inst_t     inst2,
	input  logic                  inst2_valid,
	input  logic                  recover,       // one-cycle mispredict pulse
	input  logic                  retire_valid,
	input  rename_pkg::arch_reg_t retire_arch,
	input  rename_pkg::prf_tag_t  retire_tag,
	output rename_pkg::prf_tag_t  opa_tag1,
	output rename_pkg::prf_tag_t  opb_tag1,
	output rename_pkg::prf_tag_t  dest_tag1,
	output logic                  halt1,
	output rename_pkg::prf_tag_t  opa_tag2,
	output rename_pkg::prf_tag_t  opb_tag2,
	output rename_pkg::prf_tag_t  dest_tag2,
	output logic                  halt2
);
	import rename_pkg::*;

	arch_reg_t               opa_arch1, opb_arch1, dest_arch1;   // decode to rat
	arch_reg_t               opa_arch2, opb_arch2, dest_arch2;
	logic                    opa_used1, opb_used1, dest_used1;
	logic                    opa_used2, opb_used2, dest_used2;
	prf_tag_t                free_tag1, free_tag2;               // free list offers
	logic                    free_ok1, free_ok2;
	logic [1:0]              alloc_count;
	logic [PRF_SIZE-1:0]     recover_free;
	prf_tag_t [ARF_SIZE-1:0] committed_map;                      // rrat to rat
	prf_tag_t                retire_free_tag;
	logic                    retire_free_valid;

	rename_decode rename_decode_inst (.*);

	rat #(.PRF_SIZE(PRF_SIZE)) rat_inst (.*);

	prf_free_list #(.PRF_SIZE(PRF_SIZE)) prf_free_list_inst (.*);

	rrat #(.PRF_SIZE(PRF_SIZE)) rrat_inst (.*);

endmodule

// ==== rtl/rrat.sv ====
`timescale 1ns/1ps

module rrat #(
	parameter int PRF_SIZE = 48
) (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic                                           recover,
	input  logic                                           retire_valid,
	input  rename_pkg::arch_reg_t                          retire_arch,
	input  rename_pkg::prf_tag_t                           retire_tag,
	output rename_pkg::prf_tag_t [rename_pkg::ARF_SIZE-1:0] committed_map,
	output rename_pkg::prf_tag_t                           retire_free_tag,
	output logic                                           retire_free_valid
);
	import rename_pkg::*;

	localparam prf_tag_t NO_REG = prf_tag_t'(PRF_SIZE);

	logic retire_ok;                      // retirement that updates the map

	// no retirement in a recover cycle, and zero reg never maps
	assign retire_ok = retire_valid & ~recover & (retire_arch != ZERO_REG) &
		(retire_tag != NO_REG);

	assign retire_free_tag   = committed_map[retire_arch];  // tag being replaced
	assign retire_free_valid = retire_ok;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				committed_map[i] <= prf_tag_t'(i);  // identity map
			end
		end else if (retire_ok) begin
			committed_map[retire_arch] <= retire_tag;
		end
	end

endmodule

// ==== test/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

////////////////////
// table rows and model state
////////////////////

typedef struct {
	inst_t     i1, i2;
	logic      v1, v2, rec, rv;
	arch_reg_t ra;                            // retirement, filled from the pending queue
	prf_tag_t  rt;
	prf_tag_t  opa1, opb1, dst1, opa2, opb2, dst2;
	logic      h1, h2;
} row_t;

row_t                rows[$];
prf_tag_t            spec_map   [ARF_SIZE];   // model rat
prf_tag_t            commit_map [ARF_SIZE];   // model rrat
logic [PRF_SIZE-1:0] free_mask;
prf_tag_t            offer[$];                // free tags this cycle, lowest first
arch_reg_t           pend_arch[$];            // renamed and not yet retired, oldest first
prf_tag_t            pend_tag[$];
inst_t               held[$];                 // halted work presented again

function automatic inst_t encode(input logic [5:0] op, input int ra, rb, lit, rc);
	return {op, 5'(ra), 5'(rb), 3'b000, 1'(lit), 7'b0000000, 5'(rc)};
endfunction

function automatic inst_t random_inst();
	inst_t w;
	w = $urandom;                             // random fields and literal bit
	case ($urandom % 6)
		0, 1: w[31:26] = OP_INTA + 6'($urandom % 4);
		2: w[31:26] = OP_LDL + 6'($urandom % 2);
		3: w[31:26] = OP_STL + 6'($urandom % 2);
		4: w[31:26] = OP_BR_LO + 6'($urandom % 8);
		default: w[31:26] = 6'($urandom % 8);    // opcodes with no registers
	endcase
	return w;
endfunction

task automatic model_reset();
	for (int i = 0; i < ARF_SIZE; i++) begin
		spec_map[i]   = prf_tag_t'(i);
		commit_map[i] = prf_tag_t'(i);
	end
	for (int t = 0; t < PRF_SIZE; t++) free_mask[t] = (t >= ARF_SIZE);
endtask

// field selection straight from the opcode classes
task automatic decode_fields(input inst_t w, input logic v, output arch_reg_t a, b, d,
		output logic ua, ub, ud);
	logic [5:0] op;
	logic       int_op;
	logic       ld_op;
	logic       st_op;
	op     = w[31:26];
	int_op = op >= OP_INTA && op <= OP_INTM;
	ld_op  = op == OP_LDL || op == OP_LDQ;
	st_op  = op == OP_STL || op == OP_STQ;
	a  = w[25:21];
	b  = w[20:16];
	d  = ld_op ? w[25:21] : w[4:0];           // loads write ra
	ua = v && a != ZERO_REG && (int_op || st_op || (op >= OP_BR_LO && op <= OP_BR_HI));
	ub = v && b != ZERO_REG && ((int_op && !w[12]) || ld_op || st_op);
	ud = v && d != ZERO_REG && (int_op || ld_op);
endtask

// one slot in program order, reads before its own write
task automatic rename_slot(input arch_reg_t a, b, d, input logic ua, ub, ud,
		output prf_tag_t opa, opb, dst);
	opa = ua ? spec_map[a] : NO_REG;
	opb = ub ? spec_map[b] : NO_REG;
	dst = NO_REG;
	if (ud) begin
		dst = offer.pop_front();
		spec_map[d]    = dst;
		free_mask[dst] = 1'b0;
		pend_arch.push_back(d);
		pend_tag.push_back(dst);
	end
endtask

task automatic add_row(input inst_t i1, input logic v1, input inst_t i2, input logic v2,
		input logic rec, input logic ret);
	row_t      r;
	arch_reg_t a1, b1, d1, a2, b2, d2;
	logic      ua1, ub1, ud1, ua2, ub2, ud2;
	r = '{i1, i2, v1, v2, rec, 1'b0, '0, '0,
		NO_REG, NO_REG, NO_REG, NO_REG, NO_REG, NO_REG, 1'b0, 1'b0};
	decode_fields(i1, v1, a1, b1, d1, ua1, ub1, ud1);
	decode_fields(i2, v2, a2, b2, d2, ua2, ub2, ud2);
	if (rec) begin
		for (int i = 0; i < ARF_SIZE; i++) begin
			if (spec_map[i] != commit_map[i]) free_mask[spec_map[i]] = 1'b1;
		end
		spec_map = commit_map;                    // flush, nothing renamed
		pend_arch.delete();
		pend_tag.delete();
	end else begin
		if (ret && pend_arch.size() > 0) begin    // oldest result commits
			r.rv = 1'b1;
			r.ra = pend_arch.pop_front();
			r.rt = pend_tag.pop_front();
		end
		offer.delete();
		for (int t = 0; t < PRF_SIZE; t++) if (free_mask[t]) offer.push_back(prf_tag_t'(t));
		r.h1 = ud1 && offer.size() < 1;
		r.h2 = r.h1 || (ud2 && offer.size() < (ud1 ? 2 : 1));
		if (!r.h1) rename_slot(a1, b1, d1, ua1, ub1, ud1, r.opa1, r.opb1, r.dst1);
		if (!r.h2) rename_slot(a2, b2, d2, ua2, ub2, ud2, r.opa2, r.opb2, r.dst2);
		if (r.rv) begin
			free_mask[commit_map[r.ra]] = 1'b1;   // replaced tag, usable next cycle
			commit_map[r.ra] = r.rt;
		end
	end
	rows.push_back(r);
endtask

`endif

// ==== test/rename_stage_tb.sv ====
`timescale 1ns/1ps

module rename_stage_tb;
	import rename_pkg::*;

	localparam int       PRF_SIZE = 48;
	localparam prf_tag_t NO_REG   = prf_tag_t'(PRF_SIZE);   // no-register tag

	logic      clock;
	logic      reset;
	inst_t     inst1;
	inst_t     inst2;
	logic      inst1_valid;
	logic      inst2_valid;
	logic      recover;
	logic      retire_valid;
	arch_reg_t retire_arch;
	prf_tag_t  retire_tag;
	prf_tag_t  opa_tag1, opb_tag1, dest_tag1;
	prf_tag_t  opa_tag2, opb_tag2, dest_tag2;
	logic      halt1, halt2;

	`include "rename_model.svh"

	rename_stage #(.PRF_SIZE(PRF_SIZE)) rename_stage_inst (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;           // 40 ns period
	end

	initial begin
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	////////////////////
	// checks
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_tag(input string name, input prf_tag_t got, input prf_tag_t want);
		if (got !== want) begin
			stop_run($sformatf("Mismatch at %0t: %s got %0d, expected %0d",
				$time, name, got, want));
		end
	endtask

	task automatic check_halt(input string name, input logic got, input logic want);
		if (got !== want) begin
			stop_run($sformatf("Mismatch at %0t: %s got %b, expected %b",
				$time, name, got, want));
		end
	endtask

	task automatic build_table();
		inst_t wa;
		inst_t wb;
		model_reset();
		// identity map, zero reg and literal, then two invalid slots
		add_row(encode(OP_INTA, 1, 2, 0, 3), 1, encode(OP_INTL, 31, 7, 1, 5), 1, 0, 0);
		add_row(encode(OP_INTA, 1, 2, 0, 6), 0, encode(OP_LDQ, 8, 9, 0, 0), 0, 0, 0);
		// decode classes, slot 2 bypass, same destination
		add_row(encode(OP_LDQ, 4, 6, 0, 0), 1, encode(OP_STQ, 3, 5, 0, 0), 1, 0, 0);
		add_row(encode(OP_INTM, 3, 31, 0, 4), 1, encode(OP_BR_LO, 4, 0, 0, 0), 1, 0, 0);
		add_row(encode(OP_INTS, 1, 2, 0, 9), 1, encode(OP_INTL, 9, 9, 0, 9), 1, 0, 0);
		add_row(encode(6'h00, 1, 2, 0, 3), 1, encode(OP_BR_HI, 9, 0, 0, 0), 1, 0, 0);
		add_row('0, 0, '0, 0, 0, 1);             // retirement frees the old tag
		add_row(encode(OP_INTA, 5, 31, 1, 12), 1, '0, 0, 0, 0);
		// run the list dry so that one retirement lets slot 1 through
		wa = encode(OP_INTA, 1, 2, 0, 10);
		wb = encode(OP_INTA, 10, 2, 0, 11);
		repeat (8) add_row(wa, 1, wb, 1, 0, 0);
		add_row(wa, 1, wb, 1, 0, 1);
		add_row(wa, 1, wb, 1, 0, 0);
		while (pend_arch.size() > 0) add_row('0, 0, '0, 0, 0, 1);
		// speculative writes, flush, committed reads, freed tags reused
		add_row(encode(OP_INTA, 1, 2, 0, 20), 1, encode(OP_LDL, 21, 20, 0, 0), 1, 0, 0);
		add_row(wa, 1, wb, 1, 1, 0);
		add_row(encode(OP_BR_LO, 20, 0, 0, 0), 1, encode(OP_BR_LO, 21, 0, 0, 0), 1, 0, 0);
		add_row(encode(OP_INTA, 20, 21, 0, 22), 1, encode(OP_INTA, 22, 21, 0, 23), 1, 0, 0);
		// random mix, halted slots held, retirement slower than rename
		repeat (300) begin
			while (held.size() < 2) held.push_back(random_inst());
			add_row(held[0], 1, held[1], 1, 0, $urandom % 4 != 0);
			repeat (rows[$].h1 ? 0 : rows[$].h2 ? 1 : 2) held.delete(0);
		end
	endtask

	////////////////////
	// main loop
	////////////////////

	initial begin
		row_t r;
		int   waited;
		reset        = 1'b1;
		inst1        = '0;
		inst2        = '0;
		inst1_valid  = 1'b0;
		inst2_valid  = 1'b0;
		recover      = 1'b0;
		retire_valid = 1'b0;
		retire_arch  = '0;
		retire_tag   = '0;
		void'($urandom(32'h9296_7fea));       // one seed for the run
		build_table();
		waited = 0;
		while (reset) begin
			@(negedge clock);
			waited++;
			if (waited > 20) stop_run("Reset was still high 20 cycles after the start");
		end
		foreach (rows[n]) begin
			@(negedge clock);
			r = rows[n];
			inst1        = r.i1;
			inst1_valid  = r.v1;
			inst2        = r.i2;
			inst2_valid  = r.v2;
			recover      = r.rec;
			retire_valid = r.rv;
			retire_arch  = r.ra;
			retire_tag   = r.rt;
			#10;                                // settled well ahead of the rising edge
			check_tag("opa_tag1", opa_tag1, r.opa1);
			check_tag("opb_tag1", opb_tag1, r.opb1);
			check_tag("dest_tag1", dest_tag1, r.dst1);
			check_tag("opa_tag2", opa_tag2, r.opa2);
			check_tag("opb_tag2", opb_tag2, r.opb2);
			check_tag("dest_tag2", dest_tag2, r.dst2);
			check_halt("halt1", halt1, r.h1);
			check_halt("halt2", halt2, r.h2);
		end
		$display("Verification passed");
		$finish;
	end

endmodule
